// ==== rtl/pf_fifo_pkg.sv ====
// widths, depth and flag thresholds of the prefetch FIFO
// word, address and level vector types
// fill state of the read-ahead path

package pf_fifo_pkg;

  ////////////////////
  // sizes
  ////////////////////

  localparam int data_w  = 32;           // one FIFO word
  localparam int depth_w = 4;            // RAM address bits
  localparam int depth   = 16;           // RAM entries
  localparam int level_w = 5;            // holds 0..depth

  ////////////////////
  // flag thresholds
  ////////////////////

  localparam int almost_full_lvl  = 14;  // high at or above
  localparam int almost_empty_lvl = 2;   // high at or below

  ////////////////////
  // types
  ////////////////////

  typedef logic [data_w-1:0]  data_t;    // payload word
  typedef logic [depth_w-1:0] addr_t;    // RAM address
  typedef logic [level_w-1:0] level_t;   // words held in RAM

  // words read from RAM and not yet popped,
  // counting the RAM read register and the output buffer
  typedef enum logic [1:0]
  {
    pf_zero,
    pf_one,
    pf_two
  } pf_fill_e;

endpackage

// ==== rtl/sdp_ram.sv ====
// simple dual-port RAM, depth x data_w
// one write port, one registered read port

module sdp_ram
  import pf_fifo_pkg::*;
(
  input  logic  rd_clk,      // single clock for both ports
  input  logic  wr_push,     // accepted write
  input  addr_t wr_addr,     // write address from ctrl
  input  data_t wr_data,     // write word
  input  logic  ram_rd,      // read strobe from read-ahead
  input  addr_t rd_addr,     // read address from ctrl
  output data_t ram_rdata    // registered read word
);

  ////////////////////
  // storage
  ////////////////////

  data_t mem [depth];        // word array
  data_t rdata_q;            // read register

  // write port
  always_ff @(posedge rd_clk)
  begin
    if (wr_push)
    begin
      mem[wr_addr] <= wr_data;  // store accepted word
    end
  end

  ////////////////////
  // read port
  ////////////////////

  // ctrl never lets a read hit the slot being written,
  // so no bypass is needed here
  always_ff @(posedge rd_clk)
  begin
    if (ram_rd)
    begin
      rdata_q <= mem[rd_addr];  // capture on strobe only
    end
  end

  assign ram_rdata = rdata_q;   // holds until next strobe

endmodule

// ==== rtl/fifo_ctrl.sv ====
// write and read pointers of the RAM
// occupancy count and water level
// full, empty and almost flags

module fifo_ctrl
  import pf_fifo_pkg::*;
(
  input  logic   rd_clk,
  input  logic   rd_rst,        // async, active high
  input  logic   wr_push,       // accepted write
  input  logic   ram_rd,        // RAM read issued
  output addr_t  wr_addr,       // next slot to write
  output addr_t  rd_addr,       // next slot to read
  output logic   full,          // RAM holds depth words
  output logic   empty,         // RAM holds nothing
  output logic   almost_full,   // level >= almost_full_lvl
  output logic   almost_empty,  // level <= almost_empty_lvl
  output level_t wr_level       // words in RAM
);

  ////////////////////
  // state
  ////////////////////

  addr_t  wr_ptr_q;             // wraps at depth
  addr_t  rd_ptr_q;             // wraps at depth
  level_t count_q;              // current occupancy
  level_t count_nxt;            // occupancy after this edge

  ////////////////////
  // pointers
  ////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      wr_ptr_q <= '0;
    end
    else if (wr_push)
    begin
      wr_ptr_q <= wr_ptr_q + 1'b1;  // natural wrap, depth is 2**depth_w
    end
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      rd_ptr_q <= '0;
    end
    else if (ram_rd)
    begin
      rd_ptr_q <= rd_ptr_q + 1'b1;  // advance per issued read
    end
  end

  assign wr_addr = wr_ptr_q;
  assign rd_addr = rd_ptr_q;

  ////////////////////
  // occupancy
  ////////////////////

  always_comb
  begin
    case ({wr_push, ram_rd})
      2'b10:   count_nxt = count_q + 1'b1;  // write only
      2'b01:   count_nxt = count_q - 1'b1;  // read only
      default: count_nxt = count_q;         // both or neither
    endcase
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      count_q <= '0;
    end
    else
    begin
      count_q <= count_nxt;
    end
  end

  assign wr_level = count_q;    // same edge as the flags

  ////////////////////
  // flags
  ////////////////////

  // registered from the next count so they line up with count_q
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      full         <= 1'b0;
      empty        <= 1'b1;
      almost_full  <= 1'b0;
      almost_empty <= 1'b1;
    end
    else
    begin
      full         <= (count_nxt == level_t'(depth));
      empty        <= (count_nxt == '0);
      almost_full  <= (count_nxt >= level_t'(almost_full_lvl));
      almost_empty <= (count_nxt <= level_t'(almost_empty_lvl));
    end
  end

  ////////////////////
  // checks
  ////////////////////

  // top gates the write with wr_vld
  a_no_push_full: assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    !(wr_push && full)
  );

  // read-ahead must respect empty
  a_no_read_empty: assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    !(ram_rd && empty)
  );

endmodule

// ==== rtl/read_prefetch.sv ====
// read-ahead control in front of the output buffer
// fill state of words read from RAM but not yet popped

module read_prefetch
  import pf_fifo_pkg::*;
(
  input  logic rd_clk,
  input  logic rd_rst,     // async, active high
  input  logic empty,      // RAM has no words
  input  logic pop,        // consumer takes a word
  output logic ram_rd,     // issue a RAM read
  output logic buf_push    // ram_rdata valid this cycle
);

  pf_fill_e fill_q;        // words in flight or buffered
  pf_fill_e fill_nxt;
  logic     buf_push_q;    // ram_rd one cycle late

  // read while there is room, or room is made by this pop
  assign ram_rd = ~empty & ((fill_q != pf_two) | pop);

  ////////////////////
  // fill state
  ////////////////////

  always_comb
  begin
    fill_nxt = fill_q;
    case ({ram_rd, pop})
      2'b10:                       // one more word taken from RAM
        case (fill_q)
          pf_zero: fill_nxt = pf_one;
          default: fill_nxt = pf_two;
        endcase
      2'b01:                       // one word handed out
        case (fill_q)
          pf_two:  fill_nxt = pf_one;
          default: fill_nxt = pf_zero;
        endcase
      default: fill_nxt = fill_q;  // in and out balance
    endcase
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      fill_q     <= pf_zero;
      buf_push_q <= 1'b0;
    end
    else
    begin
      fill_q     <= fill_nxt;
      buf_push_q <= ram_rd;        // RAM word lands next cycle
    end
  end

  assign buf_push = buf_push_q;

  ////////////////////
  // checks
  ////////////////////

  // rd_vld from the buffer must agree with the fill count
  a_no_pop_zero: assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    !(pop && (fill_q == pf_zero))
  );

endmodule

// ==== rtl/out_reg_fifo.sv ====
// two-entry register FIFO on the read side
// head slot drives rd_data, tail slot backs it up

module out_reg_fifo
  import pf_fifo_pkg::*;
(
  input  logic  rd_clk,
  input  logic  rd_rst,      // async, active high
  input  logic  buf_push,    // ram_rdata valid
  input  data_t ram_rdata,   // word from RAM read register
  input  logic  rd_en,       // consumer ready
  output data_t rd_data,     // head word
  output logic  rd_vld       // head occupied
);

  ////////////////////
  // slots
  ////////////////////

  data_t head_q;             // oldest word
  data_t tail_q;             // next word
  logic  head_vld_q;
  logic  tail_vld_q;

  logic  pop;                // head leaves this edge
  logic  head_free;          // head empty once the pop is counted
  logic  head_vld_nxt;
  logic  tail_vld_nxt;

  assign pop = rd_en & head_vld_q;

  // after a pop the tail becomes the head
  assign head_free = pop ? ~tail_vld_q : ~head_vld_q;

  always_comb
  begin
    head_vld_nxt = (pop ? tail_vld_q : head_vld_q) | buf_push;
    tail_vld_nxt = (pop ? 1'b0 : tail_vld_q) | (buf_push & ~head_free);
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      head_vld_q <= 1'b0;
      tail_vld_q <= 1'b0;
    end
    else
    begin
      head_vld_q <= head_vld_nxt;
      tail_vld_q <= tail_vld_nxt;
    end
  end

  ////////////////////
  // payload
  ////////////////////

  always_ff @(posedge rd_clk)
  begin
    if (pop && tail_vld_q)
    begin
      head_q <= tail_q;          // shift up
    end
    if (buf_push)
    begin
      if (head_free)
      begin
        head_q <= ram_rdata;     // straight into head
      end
      else
      begin
        tail_q <= ram_rdata;     // park behind head
      end
    end
  end

  assign rd_data = head_q;       // stable while stalled
  assign rd_vld  = head_vld_q;

  ////////////////////
  // checks
  ////////////////////

  // read-ahead must never send a third word
  a_no_overflow: assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    !(buf_push && head_vld_q && tail_vld_q && !pop)
  );

endmodule

// ==== rtl/prefetch_fifo.sv ====
// prefetching FIFO top level
// RAM, pointer control, read-ahead and output buffer

module prefetch_fifo
  import pf_fifo_pkg::*;
(
  input  logic   rd_clk,
  input  logic   rd_rst,        // async, active high
  input  data_t  wr_data,       // writer word
  input  logic   wr_en,         // writer request
  output logic   wr_vld,        // space available
  output data_t  rd_data,       // head word
  input  logic   rd_en,         // consumer ready
  output logic   rd_vld,        // head word valid
  output logic   almost_full,   // RAM near full
  output logic   almost_empty,  // RAM near empty
  output level_t wr_level       // words in RAM
);

  ////////////////////
  // wires
  ////////////////////

  logic  wr_push;               // accepted write
  logic  pop;                   // accepted read
  logic  full;
  logic  empty;
  logic  ram_rd;                // read strobe into RAM
  logic  buf_push;              // RAM word into buffer
  addr_t wr_addr;
  addr_t rd_addr;
  data_t ram_rdata;

  assign wr_vld  = ~full;
  assign wr_push = wr_en & wr_vld;
  assign pop     = rd_vld & rd_en;

  ////////////////////
  // blocks
  ////////////////////

  sdp_ram u_ram (
    .rd_clk    (rd_clk),
    .wr_push   (wr_push),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .ram_rd    (ram_rd),
    .rd_addr   (rd_addr),
    .ram_rdata (ram_rdata)
  );

  fifo_ctrl u_ctrl (
    .rd_clk       (rd_clk),
    .rd_rst       (rd_rst),
    .wr_push      (wr_push),
    .ram_rd       (ram_rd),
    .wr_addr      (wr_addr),
    .rd_addr      (rd_addr),
    .full         (full),
    .empty        (empty),
    .almost_full  (almost_full),
    .almost_empty (almost_empty),
    .wr_level     (wr_level)
  );

  read_prefetch u_prefetch (
    .rd_clk   (rd_clk),
    .rd_rst   (rd_rst),
    .empty    (empty),
    .pop      (pop),
    .ram_rd   (ram_rd),
    .buf_push (buf_push)
  );

  out_reg_fifo u_out (
    .rd_clk    (rd_clk),
    .rd_rst    (rd_rst),
    .buf_push  (buf_push),
    .ram_rdata (ram_rdata),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .rd_vld    (rd_vld)
  );

endmodule

// ==== sim/tb_prefetch_fifo.sv ====
// testbench for the prefetching FIFO
// clock, reset, phased and random stimulus, queue model
// concurrent checks on order, stability, capacity and empty

module tb_prefetch_fifo
  import pf_fifo_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////
  // DUT signals
  ////////////////////

  logic   rd_clk;
  logic   rd_rst;
  data_t  wr_data;
  logic   wr_en;
  logic   wr_vld;
  data_t  rd_data;
  logic   rd_en;
  logic   rd_vld;
  logic   almost_full;
  logic   almost_empty;
  level_t wr_level;

  data_t  model_q [$];        // words accepted and not yet popped
  int     model_size;         // queue size after the last edge
  data_t  model_front;        // oldest word after the last edge
  logic   held_q;             // word shown and not taken last edge
  data_t  held_data;          // rd_data at that edge
  integer seed;
  int     i;

  prefetch_fifo dut0 (
    .rd_clk       (rd_clk),
    .rd_rst       (rd_rst),
    .wr_data      (wr_data),
    .wr_en        (wr_en),
    .wr_vld       (wr_vld),
    .rd_data      (rd_data),
    .rd_en        (rd_en),
    .rd_vld       (rd_vld),
    .almost_full  (almost_full),
    .almost_empty (almost_empty),
    .wr_level     (wr_level)
  );

  initial
  begin
    rd_clk = 1'b0;
    forever #5 rd_clk = ~rd_clk;  // 10 ns period
  end

  ////////////////////
  // failure handling
  ////////////////////

  task automatic fail_run(input string what);
    begin
      $display("%s", what);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
    end
  endtask

  task automatic value_mismatch(input string sig, input logic [31:0] exp,
                                input logic [31:0] act);
    begin
      fail_run($sformatf("CHECK FAILED at time %0t: %s expected %0h actual %0h",
                         $time, sig, exp, act));
    end
  endtask

  task automatic check_value(input string sig, input logic [31:0] exp,
                             input logic [31:0] act);
    begin
      assert (act === exp)
        else value_mismatch(sig, exp, act);
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  always @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      model_q.delete();
      model_size  <= 0;
      model_front <= '0;
      held_q      <= 1'b0;
      held_data   <= '0;
    end
    else
    begin
      if (rd_vld && rd_en && (model_q.size() != 0))
      begin
        void'(model_q.pop_front());     // consumer took the head
      end
      if (wr_en && wr_vld)
      begin
        model_q.push_back(wr_data);     // accepted write
      end
      model_size  <= model_q.size();
      model_front <= (model_q.size() != 0) ? model_q[0] : '0;
      held_q      <= rd_vld && !rd_en;  // back-pressure this edge
      held_data   <= rd_data;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  a_order: assert property (@(posedge rd_clk) disable iff (rd_rst)
    (rd_vld && rd_en) |-> (rd_data == model_front))
    else value_mismatch("rd_data", $sampled(model_front), $sampled(rd_data));

  a_hold_vld: assert property (@(posedge rd_clk) disable iff (rd_rst)
    held_q |-> rd_vld)
    else value_mismatch("rd_vld", 1, $sampled(rd_vld));

  a_hold_data: assert property (@(posedge rd_clk) disable iff (rd_rst)
    held_q |-> (rd_data == held_data))
    else value_mismatch("rd_data", $sampled(held_data), $sampled(rd_data));

  a_capacity: assert property (@(posedge rd_clk) disable iff (rd_rst)
    model_size <= depth + 2)
    else fail_run("FIFO accepted more words than RAM plus read-ahead can hold");

  a_empty: assert property (@(posedge rd_clk) disable iff (rd_rst)
    (model_size == 0) |-> !rd_vld)
    else fail_run("rd_vld was high although no word was left to read");

  ////////////////////
  // waits
  ////////////////////

  // writes every cycle until the FIFO refuses a word
  task automatic fill_until_blocked(input int limit);
    int n;
    begin
      n = 0;
      wr_en   <= 1'b1;
      wr_data <= $random(seed);
      @(posedge rd_clk);
      while (wr_vld && n < limit)
      begin
        wr_data <= $random(seed);      // fresh word per accepted write
        @(posedge rd_clk);
        n = n + 1;
      end
      wr_en <= 1'b0;
      if (wr_vld)
        fail_run("wr_vld never fell while writing with no reads");
    end
  endtask

  task automatic wait_for_drain(input int limit);
    int n;
    begin
      n = 0;
      while (model_size != 0 && n < limit)
      begin
        @(posedge rd_clk);
        n = n + 1;
      end
      if (model_size != 0)
        fail_run("FIFO did not hand out all stored words in time");
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////

  initial
  begin
    seed    = 52691;
    rd_rst  = 1'b1;
    wr_en   = 1'b0;
    rd_en   = 1'b0;
    wr_data = '0;
    repeat (10) @(posedge rd_clk);
    rd_rst <= 1'b0;
    @(posedge rd_clk);

    // values straight out of reset
    check_value("wr_vld", 1, wr_vld);
    check_value("rd_vld", 0, rd_vld);
    check_value("almost_full", 0, almost_full);
    check_value("almost_empty", 1, almost_empty);
    check_value("wr_level", 0, wr_level);
    check_value("ram_rd", 0, dut0.ram_rd);
    check_value("buf_push", 0, dut0.buf_push);

    // fill with no reads, 16 in RAM plus 2 read ahead
    fill_until_blocked(100);
    check_value("model_size", depth + 2, model_size);
    check_value("wr_level", depth, wr_level);
    check_value("almost_full", 1, almost_full);

    repeat (8) @(posedge rd_clk);      // stall with head shown

    // drain, then leave the read side idle
    rd_en <= 1'b1;
    wait_for_drain(100);
    rd_en <= 1'b0;
    repeat (4) @(posedge rd_clk);
    check_value("rd_vld", 0, rd_vld);
    check_value("almost_empty", 1, almost_empty);

    // random mix, write heavy then read heavy
    for (i = 0; i < 2000; i = i + 1)
    begin
      if (i < 1000)
        wr_en <= (($random(seed) & 3) != 0);
      else
        wr_en <= (($random(seed) & 3) == 0);
      rd_en   <= (($random(seed) & 1) != 0);
      wr_data <= $random(seed);
      @(posedge rd_clk);
    end

    // read back whatever is left
    wr_en <= 1'b0;
    rd_en <= 1'b1;
    wait_for_drain(200);
    rd_en <= 1'b0;
    @(posedge rd_clk);
    check_value("wr_level", 0, wr_level);
    check_value("rd_vld", 0, rd_vld);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== list.f ====
rtl/pf_fifo_pkg.sv
rtl/sdp_ram.sv
rtl/fifo_ctrl.sv
rtl/read_prefetch.sv
rtl/out_reg_fifo.sv
rtl/prefetch_fifo.sv
sim/tb_prefetch_fifo.sv
